// File: Bender.yml
package:
  name: noc_chain

export_include_dirs:
  - .

sources:
  - files:
      - noc_pkg.sv
      - flit_if.sv
      - packet_injector.sv
      - chain_router.sv
      - eject_accumulator.sv
      - noc_chain_top.sv
  - target: test
    files:
      - noc_chain_assertions.sv
      - tb_noc_chain.sv

// File: chain_router.sv
// One chain node; holds one flit and ejects it locally, forwards it east or drops it
`include "noc_consts.svh"

module chain_router import noc_pkg::*; #(
    parameter int NODE_ID = 0
) (
    input  logic      clk,
    input  logic      reset,
    flit_if.receiver  west,
    flit_if.sender    east,
    flit_if.sender    eject,
    output logic      misroute
);

    localparam logic [1:0] ROUTE_EJECT = 2'd0;
    localparam logic [1:0] ROUTE_EAST  = 2'd1;
    localparam logic [1:0] ROUTE_DROP  = 2'd2;
    localparam bit         IS_LAST     = (NODE_ID == `NOC_NODES - 1);

    logic       full_q;        // Holding register occupied
    logic [1:0] route_q;       // Route of the held flit's packet
    logic       miss_q;        // Sticky misroute
    flit_u      data_q;
    logic       head_q;
    logic       last_q;
    head_t      west_head;
    logic [1:0] new_route;
    logic       out_ready;
    logic       accept;
    logic       leave;

    // Destination decode, only meaningful on a head flit
    always_comb begin
        west_head = west.flit.hd;
        if (west_head.dest == NODE_ID[`NOC_DEST_W-1:0]) begin
            new_route = ROUTE_EJECT;
        end else if (IS_LAST) begin
            new_route = ROUTE_DROP;    // Nowhere further east
        end else begin
            new_route = ROUTE_EAST;
        end
    end

    always_comb begin
        case (route_q)
            ROUTE_EJECT: out_ready = eject.ready;
            ROUTE_EAST:  out_ready = east.ready;
            default:     out_ready = 1'b1; // Drop consumes at once
        endcase
    end

    assign leave      = full_q && out_ready;
    assign west.ready = !full_q || out_ready; // Pass-through when draining
    assign accept     = west.valid && west.ready;

    assign eject.valid = full_q && (route_q == ROUTE_EJECT);
    assign eject.flit  = data_q;
    assign eject.head  = head_q;
    assign eject.last  = last_q;
    assign east.valid  = full_q && (route_q == ROUTE_EAST);
    assign east.flit   = data_q;
    assign east.head   = head_q;
    assign east.last   = last_q;
    assign misroute    = miss_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full_q  <= 1'b0;
            route_q <= ROUTE_EAST;
            miss_q  <= 1'b0;
        end else begin
            if (accept) begin
                full_q <= 1'b1;
            end else if (leave) begin
                full_q <= 1'b0;
            end
            // Route fixed for the packet, reloaded on each head
            if (accept && west.head) begin
                route_q <= new_route;
                if (new_route == ROUTE_DROP) begin
                    miss_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= west.flit;
            head_q <= west.head;
            last_q <= west.last;
        end
    end

endmodule

// File: eject_accumulator.sv
// Drains every eject port and keeps a payload sum and packet count per node
`include "noc_consts.svh"

module eject_accumulator (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   drain_en,
    flit_if.receiver               eject [`NOC_NODES],
    input  logic [`NOC_NODE_W-1:0] rd_node,
    output logic [`NOC_ACC_W-1:0]  rd_sum,
    output logic [`NOC_CNT_W-1:0]  rd_count
);

    logic [`NOC_ACC_W-1:0] sums [`NOC_NODES];  // Gathered for the read mux
    logic [`NOC_CNT_W-1:0] cnts [`NOC_NODES];

    for (genvar g = 0; g < `NOC_NODES; g++) begin : g_node
        logic [`NOC_ACC_W-1:0] sum_q;
        logic [`NOC_CNT_W-1:0] cnt_q;
        logic [`NOC_ACC_W-1:0] payload;
        logic                  take;

        assign eject[g].ready = drain_en;   // Stall every port together
        assign take           = eject[g].valid && drain_en;
        assign payload        = {{(`NOC_ACC_W - `NOC_DW){1'b0}}, eject[g].flit.raw};

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                sum_q <= '0;
                cnt_q <= '0;
            end else if (take) begin
                if (eject[g].head) begin
                    cnt_q <= cnt_q + 1'b1;      // One per packet
                end else begin
                    sum_q <= sum_q + payload;   // Body payloads only
                end
            end
        end

        assign sums[g] = sum_q;
        assign cnts[g] = cnt_q;
    end

    // Read port
    assign rd_sum   = sums[rd_node];
    assign rd_count = cnts[rd_node];

endmodule

// File: flist.f
+incdir+.
noc_pkg.sv
flit_if.sv
packet_injector.sv
chain_router.sv
eject_accumulator.sv
noc_chain_top.sv
noc_chain_assertions.sv
tb_noc_chain.sv

// File: flit_if.sv
// Valid/ready flit link between injector, routers and accumulator
`include "noc_consts.svh"

interface flit_if import noc_pkg::*; ();

    logic  valid;   // Sender has a flit
    logic  ready;   // Receiver takes it this edge
    flit_u flit;    // Head word or body payload
    logic  head;    // First flit of a packet
    logic  last;    // Final flit of a packet

    // Upstream side
    modport sender (output valid, flit, head, last, input ready);

    // Downstream side
    modport receiver (input valid, flit, head, last, output ready);

endinterface

// File: noc_chain_assertions.sv
// Link protocol checks for the NoC chain, bound into noc_chain_top for simulation
`include "noc_consts.svh"

module noc_chain_assertions (
    input logic clk,
    input logic reset,
    input logic cmd_valid,
    input logic cmd_ready,
    flit_if     link [`NOC_NODES+1],
    flit_if     ej   [`NOC_NODES]
);

    // Command port closes for the whole packet
    a_cmd_close: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && cmd_ready |=> !cmd_ready)
        else $error("cmd_ready high right after a command was taken");
    a_cmd_busy: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_ready) |-> $past(link[0].valid && link[0].ready && link[0].last))
        else $error("cmd_ready rose before the last flit of a packet transferred");

    for (genvar k = 0; k < `NOC_NODES; k++) begin : g_link
        // Stalled flit must not move
        a_link_hold: assert property (@(posedge clk) disable iff (reset)
            link[k].valid && !link[k].ready |=> link[k].valid && $stable(link[k].flit)
                && $stable(link[k].head) && $stable(link[k].last))
            else $error("link %0d changed before its transfer", k);
        a_eject_hold: assert property (@(posedge clk) disable iff (reset)
            ej[k].valid && !ej[k].ready |=> ej[k].valid && $stable(ej[k].flit)
                && $stable(ej[k].head) && $stable(ej[k].last))
            else $error("eject %0d changed before its transfer", k);
        a_reset_idle: assert property (@(posedge clk)
            $fell(reset) |-> !link[k].valid && !ej[k].valid)
            else $error("valid high right after reset on node %0d", k);
    end

endmodule

bind noc_chain_top noc_chain_assertions u_asrt (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .link      (link),
    .ej        (ej)
);

// File: noc_chain_top.sv
// Top level of the NoC chain; injector, router chain and eject accumulator with plain ports
`include "noc_consts.svh"

module noc_chain_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic [`NOC_DEST_W-1:0] cmd_dest,
    input  logic [`NOC_LEN_W-1:0]  cmd_len,
    input  logic [`NOC_DW-1:0]     cmd_base,
    input  logic                   drain_en,
    input  logic [`NOC_NODE_W-1:0] rd_node,
    output logic [`NOC_ACC_W-1:0]  rd_sum,
    output logic [`NOC_CNT_W-1:0]  rd_count,
    output logic                   misroute
);

    flit_if link [`NOC_NODES+1] ();     // link[k] feeds router k
    flit_if ej   [`NOC_NODES] ();       // Router k to accumulator
    logic [`NOC_NODES-1:0] miss;

    packet_injector u_inj (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_dest  (cmd_dest),
        .cmd_len   (cmd_len),
        .cmd_base  (cmd_base),
        .out       (link[0])
    );

    for (genvar k = 0; k < `NOC_NODES; k++) begin : g_router
        chain_router #(.NODE_ID(k)) u_router (
            .clk      (clk),
            .reset    (reset),
            .west     (link[k]),
            .east     (link[k+1]),
            .eject    (ej[k]),
            .misroute (miss[k])
        );
    end

    assign link[`NOC_NODES].ready = 1'b0;  // Chain end, never routed to

    eject_accumulator u_acc (
        .clk      (clk),
        .reset    (reset),
        .drain_en (drain_en),
        .eject    (ej),
        .rd_node  (rd_node),
        .rd_sum   (rd_sum),
        .rd_count (rd_count)
    );

    assign misroute = |miss;               // Only the last router can flag

endmodule

// File: noc_consts.svh
// Shared sizing constants for the NoC chain, included by the package, the RTL and the testbench
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Chain size
`define NOC_NODES 4
`define NOC_NODE_W 2                    // Enough bits to index NOC_NODES

// Flit and field widths
`define NOC_DW 32
`define NOC_DEST_W 4
`define NOC_LEN_W 4                     // Up to 15 body flits
`define NOC_TAG_W (`NOC_DW - `NOC_DEST_W - `NOC_LEN_W)

// Accumulator side
`define NOC_ACC_W 64
`define NOC_CNT_W 16                    // Packet counter per node

`endif

// File: noc_pkg.sv
// Flit types for the NoC chain, imported by modules that build or decode flits
`include "noc_consts.svh"

package noc_pkg;

    // Head flit layout, destination in the top bits
    typedef struct packed {
        logic [`NOC_DEST_W-1:0] dest;   // Target node
        logic [`NOC_LEN_W-1:0]  len;    // Number of body flits
        logic [`NOC_TAG_W-1:0]  tag;    // Packet sequence number
    } head_t;

    // One link word
    // Read as head_t on a head flit, as raw payload on a body flit
    typedef union packed {
        head_t             hd;
        logic [`NOC_DW-1:0] raw;
    } flit_u;

endpackage

// File: packet_injector.sv
// Turns top-level commands into a head flit plus a counted run of body flits
`include "noc_consts.svh"

module packet_injector import noc_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic [`NOC_DEST_W-1:0] cmd_dest,
    input  logic [`NOC_LEN_W-1:0]  cmd_len,
    input  logic [`NOC_DW-1:0]     cmd_base,
    flit_if.sender                 out
);

    logic                  busy_q;     // Packet in flight
    logic [`NOC_LEN_W-1:0] left_q;     // Body flits still to send
    logic [`NOC_TAG_W-1:0] tag_q;      // Packet counter for the head tag
    logic [`NOC_DW-1:0]    base_q;     // Next body payload
    head_t                 new_head;
    logic                  accept;
    logic                  xfer;

    assign cmd_ready = !busy_q;
    assign accept    = cmd_valid && cmd_ready;
    assign xfer      = out.valid && out.ready;

    // Head word for the incoming command
    always_comb begin
        new_head.dest = cmd_dest;
        new_head.len  = cmd_len;
        new_head.tag  = tag_q;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q    <= 1'b0;
            out.valid <= 1'b0;
            out.head  <= 1'b0;
            out.last  <= 1'b0;
            left_q    <= '0;
            tag_q     <= '0;
        end else if (accept) begin
            busy_q    <= 1'b1;
            out.valid <= 1'b1;         // Head valid next cycle
            out.head  <= 1'b1;
            out.last  <= (cmd_len == '0); // Head-only packet
            left_q    <= cmd_len;
            tag_q     <= tag_q + 1'b1;
        end else if (xfer) begin
            out.head <= 1'b0;
            if (out.last) begin
                // Packet done, reopen command port
                busy_q    <= 1'b0;
                out.valid <= 1'b0;
                out.last  <= 1'b0;
            end else begin
                left_q   <= left_q - 1'b1;
                out.last <= (left_q == 1); // Final body flit
            end
        end
    end

    // Flit word and running base
    always_ff @(posedge clk) begin
        if (accept) begin
            out.flit.hd <= new_head;
            base_q      <= cmd_base;
        end else if (xfer && !out.last) begin
            out.flit.raw <= base_q;      // base, base+1, ...
            base_q       <= base_q + 1'b1;
        end
    end

endmodule

// File: tb_noc_chain.sv
// Directed testbench for noc_chain_top; run with the compile order in flist.f, top tb_noc_chain
`include "noc_consts.svh"

module tb_noc_chain;

    localparam int POLL_LIMIT = 64;                // Reads per node before giving up
    // Flits over all tests: 4x(1+5), 1, 16x16 worst case, 1+10, 1+3
    localparam int MAX_FLITS   = 4 * 6 + 1 + 16 * 16 + 11 + 4;
    localparam int CYCLE_LIMIT = MAX_FLITS * 8 + 400; // Margin covers polling and stall window

    logic                   clk;
    logic                   reset;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic [`NOC_DEST_W-1:0] cmd_dest;
    logic [`NOC_LEN_W-1:0]  cmd_len;
    logic [`NOC_DW-1:0]     cmd_base;
    logic                   drain_en;
    logic [`NOC_NODE_W-1:0] rd_node;
    logic [`NOC_ACC_W-1:0]  rd_sum;
    logic [`NOC_CNT_W-1:0]  rd_count;
    logic                   misroute;

    logic [`NOC_ACC_W-1:0]  exp_sum [`NOC_NODES]; // Reference totals per node
    logic [`NOC_CNT_W-1:0]  exp_cnt [`NOC_NODES];
    logic [31:0]            rng;
    int                     cycles = 0;

    noc_chain_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) die("run did not finish within the cycle limit");
    end

    task automatic die(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            die($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Hold the command until the injector takes it
    task automatic send_cmd(input int dest, input int len, input logic [31:0] base);
        logic taken;
        @(posedge clk);
        #2;
        cmd_valid = 1'b1;
        cmd_dest  = dest[`NOC_DEST_W-1:0];
        cmd_len   = len[`NOC_LEN_W-1:0];
        cmd_base  = base;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = cmd_ready;     // Taken at the coming edge
            @(posedge clk);
        end
        #2 cmd_valid = 1'b0;
    endtask

    // L*B plus 0+1+..+(L-1) for the body run
    task automatic model_add(input int dest, input int len, input logic [31:0] base);
        logic [63:0] l;
        l = len;
        if (dest < `NOC_NODES) begin
            exp_sum[dest] = exp_sum[dest] + l * base + (l * (l - 1)) / 2;
            exp_cnt[dest] = exp_cnt[dest] + 1'b1;
        end
    endtask

    task automatic send_packet(input int dest, input int len, input logic [31:0] base);
        send_cmd(dest, len, base);
        model_add(dest, len, base);
    endtask

    task automatic read_node(input int n, output logic [63:0] s, output logic [15:0] c);
        @(posedge clk);
        #2 rd_node = n[`NOC_NODE_W-1:0];
        @(negedge clk);            // Read mux settled
        s = rd_sum;
        c = rd_count;
    endtask

    // Count rises on the head, so wait for the body sum as well
    task automatic expect_totals();
        logic [63:0] s;
        logic [15:0] c;
        int          tries;
        for (int n = 0; n < `NOC_NODES; n++) begin
            tries = 0;
            read_node(n, s, c);
            while ((s !== exp_sum[n] || c !== exp_cnt[n]) && tries < POLL_LIMIT) begin
                read_node(n, s, c);
                tries++;
            end
            if (c !== exp_cnt[n]) begin
                die($sformatf("node %0d packet count never reached %0d", n, exp_cnt[n]));
            end
            check($sformatf("rd_sum[%0d]", n), s, exp_sum[n]);
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check("misroute", misroute, 0);
        check("cmd_ready", cmd_ready, 1);
        expect_totals();           // Model still all zero
    endtask

    task automatic test_one_per_node();
        for (int n = 0; n < `NOC_NODES; n++) begin
            send_packet(n, 5, 32'h100 * (n + 1));
            expect_totals();       // Other nodes untouched
        end
    endtask

    task automatic test_zero_length();
        send_packet(1, 0, 32'hdead_beef);  // Head only
        expect_totals();
    endtask

    task automatic test_random_batch();
        int          dest;
        int          len;
        logic [31:0] base;
        for (int i = 0; i < 16; i++) begin
            rng  = xorshift(rng);
            dest = rng % `NOC_NODES;
            rng  = xorshift(rng);
            len  = rng[3:0];
            rng  = xorshift(rng);
            base = rng & 32'h0fff_ffff;  // Keeps base+14 from wrapping
            send_packet(dest, len, base);
        end
        expect_totals();
    endtask

    task automatic test_backpressure();
        logic [63:0] s;
        logic [15:0] c;
        @(posedge clk);
        #2 drain_en = 1'b0;
        send_cmd(2, 10, 32'h0000_4000);
        repeat (40) @(posedge clk);    // Stall reaches the injector in a few cycles
        @(negedge clk);
        check("cmd_ready", cmd_ready, 0);
        for (int n = 0; n < `NOC_NODES; n++) begin
            read_node(n, s, c);
            check($sformatf("rd_count[%0d]", n), c, exp_cnt[n]);
            check($sformatf("rd_sum[%0d]", n), s, exp_sum[n]);
        end
        model_add(2, 10, 32'h0000_4000);
        @(posedge clk);
        #2 drain_en = 1'b1;
        expect_totals();
    endtask

    task automatic test_misroute();
        int tries;
        @(negedge clk);
        check("misroute", misroute, 0);            // Legal traffic left it low
        send_cmd(`NOC_NODES, 3, 32'h0000_0055);  // One past the last node
        tries = 0;
        @(negedge clk);
        while (!misroute && tries < POLL_LIMIT) begin
            @(negedge clk);
            tries++;
        end
        if (!misroute) die("misroute never rose for a packet beyond the chain");
        expect_totals();           // Dropped flits add nothing
    endtask

    initial begin
        rng       = 32'h0ce2_627e;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_dest  = '0;
        cmd_len   = '0;
        cmd_base  = '0;
        drain_en  = 1'b1;
        rd_node   = '0;
        for (int n = 0; n < `NOC_NODES; n++) begin
            exp_sum[n] = '0;
            exp_cnt[n] = '0;
        end
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;
        test_reset_state();
        test_one_per_node();
        test_zero_length();
        test_random_batch();
        test_backpressure();
        test_misroute();
        $display("PASS: all tests");
        $finish;
    end

endmodule
